// ==== src.f ====
rtl/ssd_ctrl_pkg.sv
rtl/axil_reg_slave.sv
rtl/kernel_reg_bank.sv
rtl/cmd_issue_timer.sv
rtl/watchdog_reset.sv
rtl/ssd_ctrl_top.sv
dv/tb_clk_gen.sv
dv/tb_ssd_ctrl.sv

// ==== dv/tb_ssd_ctrl.sv ====
`timescale 1ns/1ns

module tb_ssd_ctrl;

  typedef enum logic [2:0] {
    OP_READ,
    OP_WRITE,
    OP_CMD,
    OP_WDT_RUN,
    OP_WDT_HOLD,
    OP_BUTTON
  } op_e;

  typedef struct packed {
    op_e                     op;
    ssd_ctrl_pkg::reg_idx_t  idx;
    ssd_ctrl_pkg::reg_word_t wdata;
    ssd_ctrl_pkg::reg_word_t rdata;   // Expected read data
    logic [7:0]              dly;     // Strobe delay or button hold
  } row_t;

  logic                          clk;
  logic                          rstn;
  logic                          reset_button;
  ssd_ctrl_pkg::reg_word_t [3:0] core_state;
  ssd_ctrl_pkg::axil_addr_t      araddr;
  logic                          arvalid;
  logic                          arready;
  logic                          rvalid;
  ssd_ctrl_pkg::reg_word_t       rdata;
  ssd_ctrl_pkg::axil_resp_t      rresp;
  logic                          rready;
  ssd_ctrl_pkg::axil_addr_t      awaddr;
  logic                          awvalid;
  logic                          awready;
  ssd_ctrl_pkg::reg_word_t       wdata;
  logic                          wvalid;
  logic                          wready;
  logic                          bvalid;
  ssd_ctrl_pkg::axil_resp_t      bresp;
  logic                          bready;
  logic                          cmd_valid;
  ssd_ctrl_pkg::reg_word_t       cmd_word;
  ssd_ctrl_pkg::reg_word_t       cmd_data0;
  ssd_ctrl_pkg::reg_word_t       cmd_data1;
  logic                          core_reset;

  row_t   rows [32];
  int     num_rows = 0;
  int     err_cnt = 0;
  int     fail_cnt = 0;
  int     limit = 0;
  int     wdt_cycles;
  int     pulse_cycles;
  integer seed = 37;

  // Event monitor state sampled at the falling edge
  int   cyc = 0;
  int   brise_cyc = 0;
  int   strobe_cyc = 0;
  int   strobe_cnt = 0;
  int   rst_rise_cyc = 0;
  int   rst_fall_cyc = 0;
  int   rst_rise_cnt = 0;
  int   rst_fall_cnt = 0;
  logic bvalid_d = 1'b0;
  logic core_reset_d = 1'b0;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  ssd_ctrl_top u_ssd_ctrl_top (
    .clk              (clk),
    .rstn             (rstn),
    .reset_button_i   (reset_button),
    .core_state_i     (core_state),
    .s_axil_araddr_i  (araddr),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rready_i  (rready),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bresp_o   (bresp),
    .s_axil_bready_i  (bready),
    .cmd_valid_o      (cmd_valid),
    .cmd_word_o       (cmd_word),
    .cmd_data0_o      (cmd_data0),
    .cmd_data1_o      (cmd_data1),
    .core_reset_o     (core_reset)
  );

  ////////////////////////////////
  // Cycle count, monitor, timeout
  ////////////////////////////////

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  always @(negedge clk) begin
    if (bvalid && !bvalid_d) begin
      brise_cyc = cyc;
    end
    if (cmd_valid) begin
      strobe_cnt = strobe_cnt + 1;
      strobe_cyc = cyc;
    end
    if (core_reset && !core_reset_d) begin
      rst_rise_cnt = rst_rise_cnt + 1;
      rst_rise_cyc = cyc;
    end
    if (!core_reset && core_reset_d) begin
      rst_fall_cnt = rst_fall_cnt + 1;
      rst_fall_cyc = cyc;
    end
    bvalid_d     = bvalid;
    core_reset_d = core_reset;
  end

  initial begin
    wait (limit > 0 && cyc >= limit);
    $display("Timeout: the tests did not finish within %0d cycles", limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

  ////////////////////////////////
  // Checks and bus tasks
  ////////////////////////////////

  task automatic check_value(input string what, input ssd_ctrl_pkg::reg_word_t got,
                             input ssd_ctrl_pkg::reg_word_t exp);
    assert (got === exp) else begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_event(input logic ok, input string what);
    assert (ok === 1'b1) else begin
      $display("At %0t the check failed: %s", $time, what);
      err_cnt++;
    end
  endtask

  task automatic add_row(input op_e op, input ssd_ctrl_pkg::reg_idx_t idx,
                         input ssd_ctrl_pkg::reg_word_t wd, input ssd_ctrl_pkg::reg_word_t rd,
                         input int dly);
    rows[num_rows].op    = op;
    rows[num_rows].idx   = idx;
    rows[num_rows].wdata = wd;
    rows[num_rows].rdata = rd;
    rows[num_rows].dly   = dly;
    num_rows++;
  endtask

  task automatic axil_write(input ssd_ctrl_pkg::reg_idx_t idx, input ssd_ctrl_pkg::reg_word_t data);
    logic aw_done;
    logic w_done;
    logic aw_hs;
    logic w_hs;
    int   stall;
    aw_done = 1'b0;
    w_done  = 1'b0;
    stall   = $unsigned($random(seed)) % 4;
    @(posedge clk);
    awaddr  <= {27'd0, idx, 2'b00};
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    while (!(aw_done && w_done)) begin
      @(negedge clk);
      aw_hs = awvalid && awready;
      w_hs  = wvalid && wready;
      @(posedge clk);   // Transfer edge
      if (aw_hs) begin
        awvalid <= 1'b0;
        aw_done = 1'b1;
      end
      if (w_hs) begin
        wvalid <= 1'b0;
        w_done = 1'b1;
      end
    end
    do begin
      @(negedge clk);
    end while (!bvalid);
    check_event(!awready && !wready, "write channel ready was high during the response");
    repeat (stall) begin
      @(negedge clk);
      check_event(bvalid, "write response dropped while bready was low");
    end
    @(posedge clk);
    bready <= 1'b1;
    @(negedge clk);
    check_event(bvalid, "write response missing when bready rose");
    check_value("bresp", bresp, 0);
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axil_read(input ssd_ctrl_pkg::reg_idx_t idx,
                           output ssd_ctrl_pkg::reg_word_t data);
    int stall;
    stall = $unsigned($random(seed)) % 4;
    @(posedge clk);
    araddr  <= {27'd0, idx, 2'b00};
    arvalid <= 1'b1;
    do begin
      @(negedge clk);
    end while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    do begin
      @(negedge clk);
    end while (!rvalid);
    check_event(!arready, "arready was high while read data was pending");
    repeat (stall) begin
      @(negedge clk);
      check_event(rvalid, "read data dropped while rready was low");
    end
    @(posedge clk);
    rready <= 1'b1;
    @(negedge clk);
    data = rdata;
    check_value("rresp", rresp, 0);
    @(posedge clk);
    rready <= 1'b0;
  endtask

  ////////////////////////////////
  // Row behaviors
  ////////////////////////////////

  task automatic run_cmd(input int n);
    int guard;
    axil_write(ssd_ctrl_pkg::IDX_DELAY, n);
    strobe_cnt = 0;
    axil_write(ssd_ctrl_pkg::IDX_CMD_KICK, 32'hC0DE_0000 + n);
    guard = 0;
    while (strobe_cnt == 0 && guard < n + 16) begin
      @(posedge clk);
      guard++;
    end
    repeat (n + 4) @(posedge clk);   // Room for a stray second strobe
    check_value("command strobe count", strobe_cnt, 1);
    check_value("command strobe delay", strobe_cyc - brise_cyc, n + 1);
  endtask

  task automatic run_wdt_expire();
    int guard;
    axil_write(ssd_ctrl_pkg::IDX_WDT_CLEAR, 0);
    rst_rise_cnt = 0;
    rst_fall_cnt = 0;
    axil_write(ssd_ctrl_pkg::IDX_WDT_START, 1);
    guard = 0;
    while (rst_fall_cnt == 0 && guard < wdt_cycles + pulse_cycles + 16) begin
      @(posedge clk);
      guard++;
    end
    check_event(rst_rise_cnt > 0 && rst_fall_cnt > 0, "the watchdog reset pulse never ended");
    check_event(rst_rise_cyc - brise_cyc <= wdt_cycles + 4, "the watchdog reset came too late");
    check_value("reset pulse width", rst_fall_cyc - rst_rise_cyc, pulse_cycles);
    axil_write(ssd_ctrl_pkg::IDX_WDT_START, 0);
  endtask

  task automatic run_wdt_cleared();
    axil_write(ssd_ctrl_pkg::IDX_WDT_CLEAR, 1);
    axil_write(ssd_ctrl_pkg::IDX_WDT_START, 1);
    rst_rise_cnt = 0;
    repeat (2 * wdt_cycles) @(posedge clk);
    check_value("reset pulses while cleared", rst_rise_cnt, 0);
    axil_write(ssd_ctrl_pkg::IDX_WDT_START, 0);
    axil_write(ssd_ctrl_pkg::IDX_WDT_CLEAR, 0);
  endtask

  task automatic run_button(input int hold);
    @(posedge clk);
    reset_button <= 1'b1;
    @(negedge clk);
    check_value("core_reset_o as the button is pressed", core_reset, 0);
    repeat (hold) begin
      @(negedge clk);
      check_value("core_reset_o while the button is held", core_reset, 1);
    end
    @(posedge clk);
    reset_button <= 1'b0;
    @(negedge clk);
    check_value("core_reset_o one cycle after release", core_reset, 1);
    @(negedge clk);
    check_value("core_reset_o after release", core_reset, 0);
  endtask

  task automatic run_row(input int n);
    ssd_ctrl_pkg::reg_word_t got;
    case (rows[n].op)
      OP_READ: begin
        axil_read(rows[n].idx, got);
        check_value("read data", got, rows[n].rdata);
      end
      OP_WRITE: begin
        axil_write(rows[n].idx, rows[n].wdata);
        @(negedge clk);
        case (rows[n].idx)
          ssd_ctrl_pkg::IDX_COMMAND: check_value("cmd_word_o", cmd_word, rows[n].wdata);
          ssd_ctrl_pkg::IDX_DATA0:   check_value("cmd_data0_o", cmd_data0, rows[n].wdata);
          ssd_ctrl_pkg::IDX_DATA1:   check_value("cmd_data1_o", cmd_data1, rows[n].wdata);
          default: ;
        endcase
      end
      OP_CMD:      run_cmd(rows[n].dly);
      OP_WDT_RUN:  run_wdt_expire();
      OP_WDT_HOLD: run_wdt_cleared();
      default:     run_button(rows[n].dly);
    endcase
  endtask

  ////////////////////////////////
  // Main sequence
  ////////////////////////////////

  initial begin
    int n;
    int errs_before;
    core_state[0] = 32'h0BAD_F00D;
    core_state[1] = 32'h1234_5678;
    core_state[2] = 32'h8765_4321;
    core_state[3] = 32'hCAFE_0004;
    reset_button  = 1'b0;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    wdt_cycles    = int'(ssd_ctrl_pkg::WDT_TIMEOUT_CYCLES);
    pulse_cycles  = int'(ssd_ctrl_pkg::RESET_PULSE_CYCLES);

    add_row(OP_READ, 3'd0, '0, ssd_ctrl_pkg::ARG0_RESET_VALUE, 0);
    add_row(OP_READ, 3'd5, '0, '0, 0);
    add_row(OP_READ, 3'd6, '0, '0, 0);
    add_row(OP_READ, 3'd7, '0, '0, 0);
    for (n = 1; n <= 4; n++) begin
      add_row(OP_READ, n, '0, core_state[n-1], 0);   // Index k shows state word k-1
    end
    add_row(OP_WRITE, ssd_ctrl_pkg::IDX_COMMAND, 32'h0000_00C1, '0, 0);
    add_row(OP_WRITE, ssd_ctrl_pkg::IDX_DATA0, 32'hA5A5_0D00, '0, 0);
    add_row(OP_WRITE, ssd_ctrl_pkg::IDX_DATA1, 32'h5A5A_0D11, '0, 0);
    add_row(OP_CMD, 3'd0, '0, '0, 0);
    add_row(OP_CMD, 3'd0, '0, '0, 3);
    add_row(OP_CMD, 3'd0, '0, '0, 17);
    add_row(OP_WRITE, ssd_ctrl_pkg::IDX_CMD_KICK, 32'h600D_1234, '0, 0);
    add_row(OP_READ, ssd_ctrl_pkg::IDX_CMD_KICK, '0, 32'h600D_1234, 0);
    add_row(OP_WDT_RUN, 3'd0, '0, '0, 0);
    add_row(OP_WDT_HOLD, 3'd0, '0, '0, 0);
    add_row(OP_BUTTON, 3'd0, '0, '0, 6);
    limit = num_rows * 40 + 4 * (wdt_cycles + pulse_cycles);

    wait (rstn === 1'b1);
    for (n = 0; n < num_rows; n++) begin
      errs_before = err_cnt;
      run_row(n);
      if (err_cnt == errs_before) begin
        $display("Test %0d (op %0d, index %0d): ok", n, rows[n].op, rows[n].idx);
      end else begin
        fail_cnt++;
        $display("Test %0d (op %0d, index %0d): failed", n, rows[n].op, rows[n].idx);
      end
    end
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             num_rows, num_rows - fail_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;   // 8 ns period
  end

  // Reset low for the first 10 rising edges
  initial begin
    rstn_o = 1'b0;
    repeat (10) @(posedge clk_o);
    rstn_o <= 1'b1;
  end

endmodule

// ==== rtl/ssd_ctrl_top.sv ====
`timescale 1ns/1ns

module ssd_ctrl_top (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          reset_button_i,
  input  ssd_ctrl_pkg::reg_word_t [3:0] core_state_i,
  // AXI-lite slave
  input  ssd_ctrl_pkg::axil_addr_t      s_axil_araddr_i,
  input  logic                          s_axil_arvalid_i,
  output logic                          s_axil_arready_o,
  output logic                          s_axil_rvalid_o,
  output ssd_ctrl_pkg::reg_word_t       s_axil_rdata_o,
  output ssd_ctrl_pkg::axil_resp_t      s_axil_rresp_o,
  input  logic                          s_axil_rready_i,
  input  ssd_ctrl_pkg::axil_addr_t      s_axil_awaddr_i,
  input  logic                          s_axil_awvalid_i,
  output logic                          s_axil_awready_o,
  input  ssd_ctrl_pkg::reg_word_t       s_axil_wdata_i,
  input  logic                          s_axil_wvalid_i,
  output logic                          s_axil_wready_o,
  output logic                          s_axil_bvalid_o,
  output ssd_ctrl_pkg::axil_resp_t      s_axil_bresp_o,
  input  logic                          s_axil_bready_i,
  // Command to the core
  output logic                          cmd_valid_o,
  output ssd_ctrl_pkg::reg_word_t       cmd_word_o,
  output ssd_ctrl_pkg::reg_word_t       cmd_data0_o,
  output ssd_ctrl_pkg::reg_word_t       cmd_data1_o,
  output logic                          core_reset_o
);

  ssd_ctrl_pkg::reg_idx_t  rd_idx;
  ssd_ctrl_pkg::reg_word_t rd_data;
  logic                    wr_en;
  ssd_ctrl_pkg::reg_idx_t  wr_idx;
  ssd_ctrl_pkg::reg_word_t wr_data;
  logic                    cmd_kick;
  ssd_ctrl_pkg::reg_word_t delay;
  logic                    wdt_clear;
  logic                    wdt_start;

  axil_reg_slave u_axil_reg_slave (
    .clk              (clk),
    .rstn             (rstn),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .rd_idx_o         (rd_idx),
    .rd_data_i        (rd_data),
    .wr_en_o          (wr_en),
    .wr_idx_o         (wr_idx),
    .wr_data_o        (wr_data)
  );

  kernel_reg_bank u_kernel_reg_bank (
    .clk          (clk),
    .rstn         (rstn),
    .wr_en_i      (wr_en),
    .wr_idx_i     (wr_idx),
    .wr_data_i    (wr_data),
    .rd_idx_i     (rd_idx),
    .core_state_i (core_state_i),
    .rd_data_o    (rd_data),
    .cmd_kick_o   (cmd_kick),
    .delay_o      (delay),
    .cmd_word_o   (cmd_word_o),
    .cmd_data0_o  (cmd_data0_o),
    .cmd_data1_o  (cmd_data1_o),
    .wdt_clear_o  (wdt_clear),
    .wdt_start_o  (wdt_start)
  );

  cmd_issue_timer u_cmd_issue_timer (
    .clk         (clk),
    .rstn        (rstn),
    .cmd_kick_i  (cmd_kick),
    .delay_i     (delay),
    .cmd_valid_o (cmd_valid_o)
  );

  watchdog_reset u_watchdog_reset (
    .clk            (clk),
    .rstn           (rstn),
    .wdt_clear_i    (wdt_clear),
    .wdt_start_i    (wdt_start),
    .reset_button_i (reset_button_i),
    .core_reset_o   (core_reset_o)
  );

endmodule

// ==== rtl/watchdog_reset.sv ====
`timescale 1ns/1ns

module watchdog_reset (
  input  logic clk,
  input  logic rstn,
  input  logic wdt_clear_i,
  input  logic wdt_start_i,
  input  logic reset_button_i,
  output logic core_reset_o
);

  ssd_ctrl_pkg::wdt_count_t   wdt_cnt_q;
  ssd_ctrl_pkg::pulse_count_t pulse_cnt_q;

  logic core_reset_q;
  logic wdt_run;
  logic wdt_expire;
  logic pulse;

  assign wdt_run    = wdt_start_i && !wdt_clear_i;
  assign wdt_expire = wdt_run && (wdt_cnt_q == ssd_ctrl_pkg::WDT_TIMEOUT_CYCLES - 1);
  assign pulse      = (pulse_cnt_q != '0);

  ////////////////////////////////
  // Timeout counter
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wdt_cnt_q <= '0;
    end else if (!wdt_run || wdt_expire) begin
      wdt_cnt_q <= '0;    // Held at zero when cleared or stopped
    end else begin
      wdt_cnt_q <= wdt_cnt_q + 1'b1;
    end
  end

  ////////////////////////////////
  // Pulse stretcher
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pulse_cnt_q  <= '0;
      core_reset_q <= 1'b0;
    end else begin
      if (wdt_expire) begin
        pulse_cnt_q <= ssd_ctrl_pkg::RESET_PULSE_CYCLES;
      end else if (pulse) begin
        pulse_cnt_q <= pulse_cnt_q - 1'b1;
      end
      core_reset_q <= pulse || reset_button_i;   // Button merges here
    end
  end

  assign core_reset_o = core_reset_q;

endmodule

// ==== rtl/cmd_issue_timer.sv ====
`timescale 1ns/1ns

module cmd_issue_timer (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    cmd_kick_i,
  input  ssd_ctrl_pkg::reg_word_t delay_i,
  output logic                    cmd_valid_o
);

  ssd_ctrl_pkg::reg_word_t count_q;
  logic                    active_q;
  logic                    expire;

  assign expire = active_q && (count_q == '0);

  ////////////////////////////////
  // Countdown
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      active_q <= 1'b0;
    end else if (cmd_kick_i) begin
      active_q <= 1'b1;   // Restarts a running countdown
    end else if (expire) begin
      active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_kick_i) begin
      count_q <= delay_i;
    end else if (active_q && count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // One cycle strobe when the count runs out
  assign cmd_valid_o = expire;

endmodule

// ==== rtl/kernel_reg_bank.sv ====
`timescale 1ns/1ns

module kernel_reg_bank (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          wr_en_i,
  input  ssd_ctrl_pkg::reg_idx_t        wr_idx_i,
  input  ssd_ctrl_pkg::reg_word_t       wr_data_i,
  input  ssd_ctrl_pkg::reg_idx_t        rd_idx_i,
  input  ssd_ctrl_pkg::reg_word_t [3:0] core_state_i,
  output ssd_ctrl_pkg::reg_word_t       rd_data_o,
  output logic                          cmd_kick_o,
  output ssd_ctrl_pkg::reg_word_t       delay_o,
  output ssd_ctrl_pkg::reg_word_t       cmd_word_o,
  output ssd_ctrl_pkg::reg_word_t       cmd_data0_o,
  output ssd_ctrl_pkg::reg_word_t       cmd_data1_o,
  output logic                          wdt_clear_o,
  output logic                          wdt_start_o
);

  ssd_ctrl_pkg::reg_word_t arg_q [ssd_ctrl_pkg::REG_NUM];

  logic cmd_kick_q;
  logic wdt_clear_q;
  logic wdt_start_q;
  logic wdt_idx;

  assign wdt_idx = (wr_idx_i == ssd_ctrl_pkg::IDX_WDT_CLEAR) ||
                   (wr_idx_i == ssd_ctrl_pkg::IDX_WDT_START);

  // Argument registers
  always_ff @(posedge clk) begin
    if (!rstn) begin
      arg_q[ssd_ctrl_pkg::IDX_CMD_KICK] <= ssd_ctrl_pkg::ARG0_RESET_VALUE;
    end else if (wr_en_i && !wdt_idx) begin
      arg_q[wr_idx_i] <= wr_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cmd_kick_q  <= 1'b0;
      wdt_clear_q <= 1'b0;
      wdt_start_q <= 1'b0;
    end else begin
      cmd_kick_q <= wr_en_i && (wr_idx_i == ssd_ctrl_pkg::IDX_CMD_KICK);
      if (wr_en_i && wr_idx_i == ssd_ctrl_pkg::IDX_WDT_CLEAR) wdt_clear_q <= wr_data_i[0];
      if (wr_en_i && wr_idx_i == ssd_ctrl_pkg::IDX_WDT_START) wdt_start_q <= wr_data_i[0];
    end
  end

  // Status view seen by the host
  always_comb begin
    case (rd_idx_i)
      ssd_ctrl_pkg::IDX_CMD_KICK: rd_data_o = arg_q[ssd_ctrl_pkg::IDX_CMD_KICK];
      ssd_ctrl_pkg::IDX_COMMAND:  rd_data_o = core_state_i[0];
      ssd_ctrl_pkg::IDX_DATA0:    rd_data_o = core_state_i[1];
      ssd_ctrl_pkg::IDX_DATA1:    rd_data_o = core_state_i[2];
      ssd_ctrl_pkg::IDX_DELAY:    rd_data_o = core_state_i[3];
      default:                    rd_data_o = '0;
    endcase
  end

  assign cmd_kick_o  = cmd_kick_q;
  assign delay_o     = arg_q[ssd_ctrl_pkg::IDX_DELAY];
  assign cmd_word_o  = arg_q[ssd_ctrl_pkg::IDX_COMMAND];
  assign cmd_data0_o = arg_q[ssd_ctrl_pkg::IDX_DATA0];
  assign cmd_data1_o = arg_q[ssd_ctrl_pkg::IDX_DATA1];
  assign wdt_clear_o = wdt_clear_q;
  assign wdt_start_o = wdt_start_q;

endmodule

// ==== rtl/axil_reg_slave.sv ====
`timescale 1ns/1ns

module axil_reg_slave (
  input  logic                     clk,
  input  logic                     rstn,
  // Read address and read data
  input  ssd_ctrl_pkg::axil_addr_t s_axil_araddr_i,
  input  logic                     s_axil_arvalid_i,
  output logic                     s_axil_arready_o,
  output logic                     s_axil_rvalid_o,
  output ssd_ctrl_pkg::reg_word_t  s_axil_rdata_o,
  output ssd_ctrl_pkg::axil_resp_t s_axil_rresp_o,
  input  logic                     s_axil_rready_i,
  // Write address, write data and response
  input  ssd_ctrl_pkg::axil_addr_t s_axil_awaddr_i,
  input  logic                     s_axil_awvalid_i,
  output logic                     s_axil_awready_o,
  input  ssd_ctrl_pkg::reg_word_t  s_axil_wdata_i,
  input  logic                     s_axil_wvalid_i,
  output logic                     s_axil_wready_o,
  output logic                     s_axil_bvalid_o,
  output ssd_ctrl_pkg::axil_resp_t s_axil_bresp_o,
  input  logic                     s_axil_bready_i,
  // Register bank side
  output ssd_ctrl_pkg::reg_idx_t   rd_idx_o,
  input  ssd_ctrl_pkg::reg_word_t  rd_data_i,
  output logic                     wr_en_o,
  output ssd_ctrl_pkg::reg_idx_t   wr_idx_o,
  output ssd_ctrl_pkg::reg_word_t  wr_data_o
);

  ssd_ctrl_pkg::rd_state_t rd_state_q;
  ssd_ctrl_pkg::reg_word_t rdata_q;

  logic                    awready_q;
  logic                    wready_q;
  logic                    addr_rcvd_q;
  logic                    data_rcvd_q;
  logic                    wr_en_q;
  logic                    bvalid_q;
  ssd_ctrl_pkg::reg_idx_t  wr_idx_q;
  ssd_ctrl_pkg::reg_word_t wr_data_q;

  logic ar_fire;
  logic aw_fire;
  logic w_fire;
  logic b_fire;

  assign ar_fire = s_axil_arvalid_i && s_axil_arready_o;
  assign aw_fire = s_axil_awvalid_i && awready_q;
  assign w_fire  = s_axil_wvalid_i && wready_q;
  assign b_fire  = bvalid_q && s_axil_bready_i;

  ////////////////////////////////
  // Read channel
  ////////////////////////////////

  assign rd_idx_o = s_axil_araddr_i[ssd_ctrl_pkg::REG_IDX_HI:ssd_ctrl_pkg::REG_IDX_LO];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_state_q <= ssd_ctrl_pkg::RD_IDLE;
    end else begin
      case (rd_state_q)
        ssd_ctrl_pkg::RD_IDLE: if (s_axil_arvalid_i) rd_state_q <= ssd_ctrl_pkg::RD_RESP;
        ssd_ctrl_pkg::RD_RESP: if (s_axil_rready_i) rd_state_q <= ssd_ctrl_pkg::RD_IDLE;
        default:               rd_state_q <= ssd_ctrl_pkg::RD_IDLE;
      endcase
    end
  end

  // Word captured at address accept
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata_q <= rd_data_i;
    end
  end

  assign s_axil_arready_o = (rd_state_q == ssd_ctrl_pkg::RD_IDLE);
  assign s_axil_rvalid_o  = (rd_state_q == ssd_ctrl_pkg::RD_RESP);
  assign s_axil_rdata_o   = rdata_q;
  assign s_axil_rresp_o   = '0;   // OKAY

  ////////////////////////////////
  // Write channel
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      awready_q   <= 1'b1;
      wready_q    <= 1'b1;
      addr_rcvd_q <= 1'b0;
      data_rcvd_q <= 1'b0;
      wr_en_q     <= 1'b0;
      bvalid_q    <= 1'b0;
    end else begin
      wr_en_q <= addr_rcvd_q && data_rcvd_q;  // One pulse per write
      if (aw_fire) begin
        awready_q   <= 1'b0;
        addr_rcvd_q <= 1'b1;
      end
      if (w_fire) begin
        wready_q    <= 1'b0;
        data_rcvd_q <= 1'b1;
      end
      if (addr_rcvd_q && data_rcvd_q) begin
        addr_rcvd_q <= 1'b0;
        data_rcvd_q <= 1'b0;
      end
      // Response lands with the register update
      if (wr_en_q) begin
        bvalid_q <= 1'b1;
      end else if (b_fire) begin
        bvalid_q  <= 1'b0;
        awready_q <= 1'b1;
        wready_q  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      wr_idx_q <= s_axil_awaddr_i[ssd_ctrl_pkg::REG_IDX_HI:ssd_ctrl_pkg::REG_IDX_LO];
    end
    if (w_fire) begin
      wr_data_q <= s_axil_wdata_i;  // Strobes ignored
    end
  end

  assign s_axil_awready_o = awready_q;
  assign s_axil_wready_o  = wready_q;
  assign s_axil_bvalid_o  = bvalid_q;
  assign s_axil_bresp_o   = '0;

  assign wr_en_o   = wr_en_q;
  assign wr_idx_o  = wr_idx_q;
  assign wr_data_o = wr_data_q;

endmodule

// ==== rtl/ssd_ctrl_pkg.sv ====
package ssd_ctrl_pkg;

  ////////////////////////////////
  // Widths
  ////////////////////////////////

  typedef logic [31:0] reg_word_t;    // Register and AXI data word
  typedef logic [31:0] axil_addr_t;
  typedef logic [1:0]  axil_resp_t;   // Always OKAY
  typedef logic [2:0]  reg_idx_t;

  ////////////////////////////////
  // Register map
  ////////////////////////////////

  localparam int REG_NUM    = 8;
  localparam int REG_IDX_LO = 2;      // Byte address to word
  localparam int REG_IDX_HI = 4;

  localparam reg_idx_t IDX_CMD_KICK  = 3'd0;  // Write issues a command
  localparam reg_idx_t IDX_COMMAND   = 3'd1;
  localparam reg_idx_t IDX_DATA0     = 3'd2;
  localparam reg_idx_t IDX_DATA1     = 3'd3;
  localparam reg_idx_t IDX_DELAY     = 3'd4;
  localparam reg_idx_t IDX_WDT_CLEAR = 3'd5;
  localparam reg_idx_t IDX_WDT_START = 3'd6;

  localparam reg_word_t ARG0_RESET_VALUE = 32'hDEAD_BEEF;

  ////////////////////////////////
  // Watchdog timing
  ////////////////////////////////

  typedef logic [31:0] wdt_count_t;
  typedef logic [15:0] pulse_count_t;

  localparam wdt_count_t   WDT_TIMEOUT_CYCLES = 32'd200;
  localparam pulse_count_t RESET_PULSE_CYCLES = 16'd16;

  // Read channel FSM
  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_t;

endpackage
